// File: common/analog_pkg.sv
// Shared widths, sample types and sequencer states for the analog datapath, used by scoped name
`default_nettype none

package analog_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int unsigned ADC_RAW_W    = 16;  // Raw word from one ADC channel
  localparam int unsigned ADC_LSB_DROP = 2;   // Low bits unused on the 14-bit converter
  localparam int unsigned SAMPLE_W     = 14;  // Signed sample and DAC code
  localparam int unsigned SUM_W        = 15;  // One guard bit for generator + controller

  //////////////////////////////////////////////////
  // Reset sequencing
  //////////////////////////////////////////////////

  localparam int unsigned RST_CNT_W = 7;  // Counter must also hold the final value

  // Core stays in reset this many cycles after lock
  localparam logic [RST_CNT_W-1:0] RST_HOLD_CYCLES = 7'd64;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Raw ADC word, negative-slope offset code in the upper bits
  typedef logic [ADC_RAW_W-1:0] adc_raw_t;

  // Two's complement sample inside the core
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Negative-slope offset code toward the DAC
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  // Lock tracking for the reset sequencer
  typedef enum logic [1:0] {
    SEQ_UNLOCKED = 2'd0,  // Waiting for clock lock, core not held
    SEQ_HOLD     = 2'd1,  // Lock seen, core held in reset
    SEQ_RUN      = 2'd2   // Normal operation
  } seq_state_e;

endpackage

`default_nettype wire

// File: rtl/reset_sequencer.sv
// Holds the core in reset for a fixed count after clock lock and drives the DAC reset
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer (
  input  logic adc_clk,
  input  logic rst_n_i,       // Board reset, synchronous
  input  logic pll_locked_i,  // Clock source lock status
  output logic core_rst_n_o,  // Core reset, active low
  output logic dac_rst_o      // DAC reset, active high
);

  logic                               lock_q;     // Lock delayed one cycle
  logic                               lock_rise;
  analog_pkg::seq_state_e             state_q;
  analog_pkg::seq_state_e             state_d;
  logic [analog_pkg::RST_CNT_W-1:0]   cnt_q;      // Cycles spent in hold

  assign lock_rise = pll_locked_i & ~lock_q;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      analog_pkg::SEQ_UNLOCKED: begin
        if (lock_rise)
          state_d = analog_pkg::SEQ_HOLD;
      end
      analog_pkg::SEQ_HOLD: begin
        // Losing lock drops straight out, reset is not extended
        if (!pll_locked_i)
          state_d = analog_pkg::SEQ_UNLOCKED;
        else if (cnt_q == analog_pkg::RST_HOLD_CYCLES - 1'b1)
          state_d = analog_pkg::SEQ_RUN;
      end
      analog_pkg::SEQ_RUN: begin
        if (!pll_locked_i)
          state_d = analog_pkg::SEQ_UNLOCKED;
      end
      default: state_d = analog_pkg::SEQ_UNLOCKED;
    endcase
  end

  //////////////////////////////////////////////////
  // State, counter and reset outputs
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      lock_q       <= 1'b0;  // Lock already high at release counts as a rise
      state_q      <= analog_pkg::SEQ_UNLOCKED;
      cnt_q        <= '0;
      core_rst_n_o <= 1'b0;
      dac_rst_o    <= 1'b1;
    end else begin
      lock_q  <= pll_locked_i;
      state_q <= state_d;
      // Zero on entry to hold, counts while holding
      cnt_q   <= (state_q == analog_pkg::SEQ_HOLD) ? cnt_q + 1'b1 : '0;
      // Outputs follow next state so hold starts right after the lock edge
      core_rst_n_o <= (state_d != analog_pkg::SEQ_HOLD);
      dac_rst_o    <= (state_d == analog_pkg::SEQ_HOLD);
    end
  end

endmodule

`default_nettype wire

// File: analog/adc_frontend.sv
// ADC input stage, converts raw converter words to signed samples or selects the loopback path
`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  analog_pkg::adc_raw_t adc_dat_a_i,     // Raw word CH A
  input  analog_pkg::adc_raw_t adc_dat_b_i,     // Raw word CH B
  input  logic                 digital_loop_i,  // Replace ADC with DAC samples
  input  analog_pkg::sample_t  loop_a_i,        // Mixer output CH A
  input  analog_pkg::sample_t  loop_b_i,        // Mixer output CH B
  output analog_pkg::sample_t  adc_a_o,
  output analog_pkg::sample_t  adc_b_o
);

  analog_pkg::sample_t conv_a;
  analog_pkg::sample_t conv_b;

  // Upper bits only, then negative slope to two's complement
  function automatic analog_pkg::sample_t raw_to_sample(input analog_pkg::adc_raw_t raw);
    logic [analog_pkg::SAMPLE_W-1:0] code;
    code = raw[analog_pkg::ADC_RAW_W-1:analog_pkg::ADC_LSB_DROP];
    // MSB kept, magnitude bits flipped
    return {code[analog_pkg::SAMPLE_W-1], ~code[analog_pkg::SAMPLE_W-2:0]};
  endfunction

  assign conv_a = raw_to_sample(adc_dat_a_i);
  assign conv_b = raw_to_sample(adc_dat_b_i);

  //////////////////////////////////////////////////
  // Sample register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= digital_loop_i ? loop_a_i : conv_a;  // Loop ignores ADC input
      adc_b_o <= digital_loop_i ? loop_b_i : conv_b;
    end
  end

endmodule

`default_nettype wire

// File: analog/dac_mixer.sv
// DAC mixing stage, adds generator and controller samples per channel and saturates to 14 bits
`timescale 1ns/1ps
`default_nettype none

module dac_mixer (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  analog_pkg::sample_t asg_a_i,  // Generator CH A
  input  analog_pkg::sample_t asg_b_i,  // Generator CH B
  input  analog_pkg::sample_t pid_a_i,  // Controller CH A
  input  analog_pkg::sample_t pid_b_i,  // Controller CH B
  output analog_pkg::sample_t mix_a_o,
  output analog_pkg::sample_t mix_b_o
);

  analog_pkg::sample_t sat_a;
  analog_pkg::sample_t sat_b;

  // Sign extend by one bit, add, clamp on overflow
  function automatic analog_pkg::sample_t sat_add(input analog_pkg::sample_t a,
                                                  input analog_pkg::sample_t b);
    logic [analog_pkg::SUM_W-1:0] sum;
    logic                         sign;
    sum  = {a[analog_pkg::SAMPLE_W-1], a} + {b[analog_pkg::SAMPLE_W-1], b};
    sign = sum[analog_pkg::SUM_W-1];
    // Top two bits disagree only when the result left the 14-bit range
    if (sign ^ sum[analog_pkg::SUM_W-2])
      return {sign, {(analog_pkg::SAMPLE_W-1){~sign}}};  // 8191 or -8192
    else
      return sum[analog_pkg::SAMPLE_W-1:0];
  endfunction

  assign sat_a = sat_add(asg_a_i, pid_a_i);
  assign sat_b = sat_add(asg_b_i, pid_b_i);

  //////////////////////////////////////////////////
  // Mix register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      mix_a_o <= '0;
      mix_b_o <= '0;
    end else begin
      mix_a_o <= sat_a;
      mix_b_o <= sat_b;
    end
  end

endmodule

`default_nettype wire

// File: analog/dac_output.sv
// DAC output stage, turns saturated samples into registered negative-slope converter codes
`timescale 1ns/1ps
`default_nettype none

module dac_output (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  analog_pkg::sample_t   mix_a_i,       // Saturated CH A
  input  analog_pkg::sample_t   mix_b_i,       // Saturated CH B
  output analog_pkg::dac_code_t dac_code_a_o,  // To converter CH A
  output analog_pkg::dac_code_t dac_code_b_o   // To converter CH B
);

  analog_pkg::dac_code_t code_a;
  analog_pkg::dac_code_t code_b;

  // Inverse of the ADC mapping, sign kept and magnitude flipped
  function automatic analog_pkg::dac_code_t sample_to_code(input analog_pkg::sample_t s);
    return {s[analog_pkg::SAMPLE_W-1], ~s[analog_pkg::SAMPLE_W-2:0]};
  endfunction

  assign code_a = sample_to_code(mix_a_i);
  assign code_b = sample_to_code(mix_b_i);

  //////////////////////////////////////////////////
  // Output register facing the converter
  //////////////////////////////////////////////////

  // Zero code during reset, the DAC reset line marks it invalid
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_code_a_o <= '0;
      dac_code_b_o <= '0;
    end else begin
      dac_code_a_o <= code_a;
      dac_code_b_o <= code_b;
    end
  end

endmodule

`default_nettype wire

// File: rtl/analog_top.sv
// Top level of the analog datapath, connects reset sequencing and the ADC and DAC stages to pins
`timescale 1ns/1ps
`default_nettype none

module analog_top (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,         // Board reset, active low
  input  logic                  pll_locked_i,    // Clock source locked
  input  logic                  digital_loop_i,  // DAC samples back into ADC path
  // ADC
  input  analog_pkg::adc_raw_t  adc_dat_a_i,
  input  analog_pkg::adc_raw_t  adc_dat_b_i,
  // Generator and controller samples
  input  analog_pkg::sample_t   asg_a_i,
  input  analog_pkg::sample_t   asg_b_i,
  input  analog_pkg::sample_t   pid_a_i,
  input  analog_pkg::sample_t   pid_b_i,
  // Converted ADC samples
  output analog_pkg::sample_t   adc_a_o,
  output analog_pkg::sample_t   adc_b_o,
  // DAC
  output analog_pkg::dac_code_t dac_code_a_o,
  output analog_pkg::dac_code_t dac_code_b_o,
  output logic                  dac_rst_o
);

  logic                core_rst_n;  // Stage reset from sequencer
  analog_pkg::sample_t mix_a;       // Saturated sums, to DAC and loop
  analog_pkg::sample_t mix_b;

  //////////////////////////////////////////////////
  // Reset sequencing
  //////////////////////////////////////////////////

  reset_sequencer u_reset_sequencer (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .pll_locked_i (pll_locked_i),
    .core_rst_n_o (core_rst_n),
    .dac_rst_o    (dac_rst_o)
  );

  //////////////////////////////////////////////////
  // ADC path
  //////////////////////////////////////////////////

  adc_frontend u_adc_frontend (
    .adc_clk        (adc_clk),
    .rst_n_i        (core_rst_n),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop_i),
    .loop_a_i       (mix_a),  // Loop taps before the DAC register
    .loop_b_i       (mix_b),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  //////////////////////////////////////////////////
  // DAC path
  //////////////////////////////////////////////////

  dac_mixer u_dac_mixer (
    .adc_clk (adc_clk),
    .rst_n_i (core_rst_n),
    .asg_a_i (asg_a_i),
    .asg_b_i (asg_b_i),
    .pid_a_i (pid_a_i),
    .pid_b_i (pid_b_i),
    .mix_a_o (mix_a),
    .mix_b_o (mix_b)
  );

  dac_output u_dac_output (
    .adc_clk      (adc_clk),
    .rst_n_i      (core_rst_n),
    .mix_a_i      (mix_a),
    .mix_b_i      (mix_b),
    .dac_code_a_o (dac_code_a_o),
    .dac_code_b_o (dac_code_b_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_analog_top.sv
// Directed testbench for analog_top, covers reset sequencing, ADC conversion, DAC mixing and loopback
`timescale 1ns/1ps
`default_nettype none

module tb_analog_top;

  localparam int CLK_HALF       = 20;    // 40 ns period
  localparam int DRIVE_DLY      = 2;     // Inputs change after the edge
  localparam int RST_CYCLES     = 4;
  localparam int HOLD_CYCLES    = 64;    // Core reset length after lock
  localparam int ADC_N          = 32;
  localparam int DAC_N          = 32;
  localparam int LOOP_N         = 32;
  localparam int TIMEOUT_CYCLES = 1000;  // Tests need about 190 cycles
  localparam int SAT_MAX        = 8191;
  localparam int SAT_MIN        = -8192;

  logic                  adc_clk;
  logic                  rst_n_i;
  logic                  pll_locked_i;
  logic                  digital_loop_i;
  analog_pkg::adc_raw_t  adc_dat_a_i;
  analog_pkg::adc_raw_t  adc_dat_b_i;
  analog_pkg::sample_t   asg_a_i;
  analog_pkg::sample_t   asg_b_i;
  analog_pkg::sample_t   pid_a_i;
  analog_pkg::sample_t   pid_b_i;
  analog_pkg::sample_t   adc_a_o;
  analog_pkg::sample_t   adc_b_o;
  analog_pkg::dac_code_t dac_code_a_o;
  analog_pkg::dac_code_t dac_code_b_o;
  logic                  dac_rst_o;

  int seed = 80;
  int errors;
  int checks;
  int tests_passed;
  int tests_failed;
  int cycle_cnt;
  int asg_a_q[$];  // Mixer stimulus per cycle
  int asg_b_q[$];
  int pid_a_q[$];
  int pid_b_q[$];

  analog_top u_analog_top (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .pll_locked_i   (pll_locked_i),
    .digital_loop_i (digital_loop_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .asg_a_i        (asg_a_i),
    .asg_b_i        (asg_b_i),
    .pid_a_i        (pid_a_i),
    .pid_b_i        (pid_b_i),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o),
    .dac_code_a_o   (dac_code_a_o),
    .dac_code_b_o   (dac_code_b_o),
    .dac_rst_o      (dac_rst_o)
  );

  always #CLK_HALF adc_clk = ~adc_clk;

  // Hard stop if a test stalls
  always @(posedge adc_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////

  // Upper 14 bits, magnitude bits flipped
  function automatic logic [13:0] adc_expect(input logic [15:0] raw);
    return raw[15:2] ^ 14'h1FFF;
  endfunction

  function automatic int sat_sum(input int a, input int b);
    int s;
    s = a + b;
    if (s > SAT_MAX)
      s = SAT_MAX;
    else if (s < SAT_MIN)
      s = SAT_MIN;
    return s;
  endfunction

  function automatic logic [13:0] to_sample(input int v);
    return v[13:0];
  endfunction

  function automatic logic [13:0] dac_code_of(input int s);
    return to_sample(s) ^ 14'h1FFF;  // Sign bit kept
  endfunction

  // Edge, then settle before drive and sample
  task automatic next_cycle();
    @(posedge adc_clk);
    #DRIVE_DLY;
  endtask

  task automatic check_word(input string name, input logic [13:0] act, input logic [13:0] exp);
    checks++;
    assert (act === exp) else begin
      $display("** Error [%0t] %s: expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    checks++;
    assert (act === exp) else begin
      $display("** Error [%0t] %s: expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    if (errors == err_start) begin
      $display("[%0t] %s: PASS", $time, name);
      tests_passed++;
    end else begin
      $display("[%0t] %s: FAIL with %0d errors", $time, name, errors - err_start);
      tests_failed++;
    end
  endtask

  task automatic push_pair(input int aa, input int pa, input int ab, input int pb);
    asg_a_q.push_back(aa);
    pid_a_q.push_back(pa);
    asg_b_q.push_back(ab);
    pid_b_q.push_back(pb);
  endtask

  // One pair per cycle, results two cycles later, queues emptied at the end
  task automatic run_mix_stream(input bit loop_mode);
    int n;
    int r;
    n = asg_a_q.size();
    digital_loop_i = loop_mode;
    for (int i = 0; i <= n; i++) begin
      if (i < n) begin
        asg_a_i = to_sample(asg_a_q[i]);
        pid_a_i = to_sample(pid_a_q[i]);
        asg_b_i = to_sample(asg_b_q[i]);
        pid_b_i = to_sample(pid_b_q[i]);
      end else begin
        asg_a_i = '0;
        pid_a_i = '0;
        asg_b_i = '0;
        pid_b_i = '0;
      end
      if (loop_mode) begin
        r = $random(seed);  // ADC noise, must not leak into loop
        adc_dat_a_i = r[15:0];
        adc_dat_b_i = r[31:16];
      end
      next_cycle();
      if (i >= 1) begin
        check_word("dac_code_a_o", dac_code_a_o,
                   dac_code_of(sat_sum(asg_a_q[i-1], pid_a_q[i-1])));
        check_word("dac_code_b_o", dac_code_b_o,
                   dac_code_of(sat_sum(asg_b_q[i-1], pid_b_q[i-1])));
        if (loop_mode) begin
          check_word("adc_a_o", adc_a_o, to_sample(sat_sum(asg_a_q[i-1], pid_a_q[i-1])));
          check_word("adc_b_o", adc_b_o, to_sample(sat_sum(asg_b_q[i-1], pid_b_q[i-1])));
        end
      end
    end
    digital_loop_i = 1'b0;
    asg_a_q.delete();
    asg_b_q.delete();
    pid_a_q.delete();
    pid_b_q.delete();
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic reset_values();
    int e0;
    e0 = errors;
    rst_n_i = 1'b0;
    repeat (RST_CYCLES) next_cycle();
    check_bit("dac_rst_o", dac_rst_o, 1'b1);
    check_word("adc_a_o", adc_a_o, 14'd0);
    check_word("adc_b_o", adc_b_o, 14'd0);
    check_word("dac_code_a_o", dac_code_a_o, 14'd0);
    check_word("dac_code_b_o", dac_code_b_o, 14'd0);
    finish_test("reset_values", e0);
  endtask

  // Lock raised with reset release, next edge sees the rise
  task automatic lock_hold();
    int e0;
    e0 = errors;
    rst_n_i      = 1'b1;
    pll_locked_i = 1'b1;
    for (int k = 1; k <= HOLD_CYCLES; k++) begin
      next_cycle();
      check_bit("dac_rst_o", dac_rst_o, 1'b1);
    end
    repeat (4) begin
      next_cycle();
      check_bit("dac_rst_o", dac_rst_o, 1'b0);
    end
    finish_test("lock_hold", e0);
  endtask

  task automatic adc_conversion();
    int e0;
    int r;
    e0 = errors;
    digital_loop_i = 1'b0;
    for (int i = 0; i < ADC_N; i++) begin
      r = $random(seed);
      adc_dat_a_i = r[15:0];
      adc_dat_b_i = r[31:16];
      next_cycle();
      check_word("adc_a_o", adc_a_o, adc_expect(r[15:0]));
      check_word("adc_b_o", adc_b_o, adc_expect(r[31:16]));
    end
    finish_test("adc_conversion", e0);
  endtask

  // Small operands, sum never leaves 14 bits
  task automatic dac_sum();
    int e0;
    e0 = errors;
    for (int i = 0; i < DAC_N; i++)
      push_pair($random(seed) % 4096, $random(seed) % 4096,
                $random(seed) % 4096, $random(seed) % 4096);
    run_mix_stream(1'b0);
    finish_test("dac_sum", e0);
  endtask

  task automatic dac_saturation();
    int e0;
    e0 = errors;
    push_pair(8000, 500, -8000, -500);      // Clamp both ways
    push_pair(4000, 4191, -4096, -4096);    // Exact limits
    push_pair(8191, 8191, -8192, -8192);    // Largest overflow
    push_pair(8191, -8192, -1, 0);          // Mixed signs
    push_pair(-8000, -500, 8000, 500);
    run_mix_stream(1'b0);
    finish_test("dac_saturation", e0);
  endtask

  // Full range operands, some sums clamp
  task automatic digital_loop();
    int e0;
    e0 = errors;
    for (int i = 0; i < LOOP_N; i++)
      push_pair($random(seed) % 8192, $random(seed) % 8192,
                $random(seed) % 8192, $random(seed) % 8192);
    run_mix_stream(1'b1);
    finish_test("digital_loop", e0);
  endtask

  task automatic lock_loss();
    int e0;
    e0 = errors;
    pll_locked_i = 1'b0;
    repeat (8) begin
      next_cycle();
      check_bit("dac_rst_o", dac_rst_o, 1'b0);
    end
    finish_test("lock_loss", e0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    adc_clk        = 1'b0;
    rst_n_i        = 1'b0;
    pll_locked_i   = 1'b0;
    digital_loop_i = 1'b0;
    adc_dat_a_i    = '0;
    adc_dat_b_i    = '0;
    asg_a_i        = '0;
    asg_b_i        = '0;
    pid_a_i        = '0;
    pid_b_i        = '0;
    errors         = 0;
    checks         = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    cycle_cnt      = 0;

    reset_values();
    lock_hold();
    adc_conversion();
    dac_sum();
    dac_saturation();
    digital_loop();
    lock_loss();

    $display("Tests passed: %0d, tests failed: %0d, checks: %0d, errors: %0d",
             tests_passed, tests_failed, checks, errors);
    if (tests_failed == 0 && errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
common/analog_pkg.sv
rtl/reset_sequencer.sv
analog/adc_frontend.sv
analog/dac_mixer.sv
analog/dac_output.sv
rtl/analog_top.sv
tests/tb_analog_top.sv

// File: Makefile
# Verilator build for the analog datapath

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_analog_top
RTL_TOP   ?= analog_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --timing --assert
LINTFLAGS ?= --lint-only

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
